// ==== include/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// integer data path width, rv64
`define RV_XLEN 64

// architectural integer registers x0..x31
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 64'h8000_0000

// raw instruction width, no compressed encodings
`define RV_ILEN 32

// register index width
`define RV_REG_AW 5

// sequential pc step
`define RV_PC_STEP 4

`endif

// ==== verilog/rv_core_pkg.sv ====
`include "rv_core_defs.svh"

package rv_core_pkg;

  // one architectural data word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index into the integer file
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // raw 32-bit instruction as delivered by the fetch side
  typedef logic [`RV_ILEN-1:0] inst_t;

  // decoded instruction kind
  // invalid covers every encoding outside the supported subset,
  // the all-zero word included
  typedef enum logic [2:0] {
    KIND_ADDI    = 3'd0,
    KIND_LUI     = 3'd1,
    KIND_AUIPC   = 3'd2,
    KIND_JAL     = 3'd3,
    KIND_JALR    = 3'd4,
    KIND_EBREAK  = 3'd5,
    KIND_INVALID = 3'd6
  } inst_kind_e;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // ebreak is one fixed word in the system opcode space
  localparam inst_t INST_EBREAK = 32'h0010_0073;

endpackage

// ==== verilog/rv_decode_if.sv ====
// one decoded instruction, decoder to execution unit
interface rv_decode_if;

  // record valid for one cycle after the decoder loads
  logic                    dec_valid;
  rv_core_pkg::word_t      pc;
  rv_core_pkg::inst_kind_e kind;

  // operands of the result adder
  rv_core_pkg::word_t      op1;
  rv_core_pkg::word_t      op2;

  // operands of the jump target adder
  rv_core_pkg::word_t      op1_jump;
  rv_core_pkg::word_t      op2_jump;
  logic                    jump;

  // destination register
  logic                    rd_wen;
  rv_core_pkg::reg_addr_t  rd_addr;

  modport producer (
    output dec_valid, pc, kind, op1, op2, op1_jump, op2_jump, jump, rd_wen, rd_addr
  );

  modport consumer (
    input dec_valid, pc, kind, op1, op2, op1_jump, op2_jump, jump, rd_wen, rd_addr
  );

endinterface

// ==== verilog/rv_regfile.sv ====
`include "rv_core_defs.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::reg_addr_t rs1_addr,
  input  logic                   wen,
  input  rv_core_pkg::reg_addr_t waddr,
  input  rv_core_pkg::word_t     wdata,
  output rv_core_pkg::word_t     rs1_data
);

  // x0 entry exists but is never written
  rv_core_pkg::word_t regs [`RV_NREGS];

  // write port, commit side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // read port, decode side, no bypass needed
  // since only one instruction is in flight
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];

endmodule

// ==== verilog/rv_idu.sv ====
`include "rv_core_defs.svh"

module rv_idu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dec_load,
  input  rv_core_pkg::word_t     pc,
  input  rv_core_pkg::inst_t     inst,
  input  rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::reg_addr_t rs1_addr,
  rv_decode_if.producer          dec,
  output rv_core_pkg::inst_t     dec_inst
);

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rd;

  // sign extended immediates
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;

  // combinational decode result
  rv_core_pkg::inst_kind_e kind;
  rv_core_pkg::word_t      op1;
  rv_core_pkg::word_t      op2;
  rv_core_pkg::word_t      op1_jump;
  rv_core_pkg::word_t      op2_jump;
  logic                    jump;
  logic                    rd_wen;

  assign opcode   = inst[6:0];
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  // rs1 always sits at the same place, read it unconditionally
  assign rs1_addr = inst[19:15];

  // I: 12 bits, U: upper 20 bits, J: scrambled 21 bits
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  // kind lookup
  always_comb begin
    kind = rv_core_pkg::KIND_INVALID;
    if (inst == rv_core_pkg::INST_EBREAK) begin
      kind = rv_core_pkg::KIND_EBREAK;
    end else begin
      case (opcode)
        rv_core_pkg::OPC_OP_IMM: if (funct3 == 3'b000) kind = rv_core_pkg::KIND_ADDI;
        rv_core_pkg::OPC_LUI:    kind = rv_core_pkg::KIND_LUI;
        rv_core_pkg::OPC_AUIPC:  kind = rv_core_pkg::KIND_AUIPC;
        rv_core_pkg::OPC_JAL:    kind = rv_core_pkg::KIND_JAL;
        rv_core_pkg::OPC_JALR:   if (funct3 == 3'b000) kind = rv_core_pkg::KIND_JALR;
        default:                 kind = rv_core_pkg::KIND_INVALID;
      endcase
    end
  end

  // operand selection per kind
  always_comb begin
    op1      = '0;
    op2      = '0;
    op1_jump = '0;
    op2_jump = '0;
    jump     = 1'b0;
    rd_wen   = 1'b0;
    case (kind)
      rv_core_pkg::KIND_ADDI: begin
        op1    = rs1_data;
        op2    = imm_i;
        rd_wen = 1'b1;
      end
      rv_core_pkg::KIND_LUI: begin
        // op1 stays zero
        op2    = imm_u;
        rd_wen = 1'b1;
      end
      rv_core_pkg::KIND_AUIPC: begin
        op1    = pc;
        op2    = imm_u;
        rd_wen = 1'b1;
      end
      rv_core_pkg::KIND_JAL: begin
        // link value pc+4, target pc+imm
        op1      = pc;
        op2      = `RV_XLEN'(`RV_PC_STEP);
        op1_jump = pc;
        op2_jump = imm_j;
        jump     = 1'b1;
        rd_wen   = 1'b1;
      end
      rv_core_pkg::KIND_JALR: begin
        op1      = pc;
        op2      = `RV_XLEN'(`RV_PC_STEP);
        op1_jump = rs1_data;
        op2_jump = imm_i;
        jump     = 1'b1;
        rd_wen   = 1'b1;
      end
      // ebreak and invalid write nothing
      default: ;
    endcase
  end

  // valid is a one cycle pulse after each load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec.dec_valid <= 1'b0;
    end else begin
      dec.dec_valid <= dec_load;
    end
  end

  // payload, captured at the input handshake
  always_ff @(posedge clk) begin
    if (dec_load) begin
      dec.pc       <= pc;
      dec.kind     <= kind;
      dec.op1      <= op1;
      dec.op2      <= op2;
      dec.op1_jump <= op1_jump;
      dec.op2_jump <= op2_jump;
      dec.jump     <= jump;
      dec.rd_wen   <= rd_wen;
      dec.rd_addr  <= rd;
      dec_inst     <= inst;
    end
  end

endmodule

// ==== verilog/rv_exu.sv ====
`include "rv_core_defs.svh"

module rv_exu (
  input  logic                    clk,
  input  logic                    rst_n,
  rv_decode_if.consumer           dec,
  input  rv_core_pkg::inst_t      dec_inst,
  input  logic                    commit_fire,
  output logic                    exu_valid,
  output rv_core_pkg::word_t      commit_pc,
  output rv_core_pkg::inst_t      commit_inst,
  output rv_core_pkg::inst_kind_e commit_kind,
  output logic                    commit_rd_wen,
  output rv_core_pkg::reg_addr_t  commit_rd,
  output rv_core_pkg::word_t      commit_data,
  output rv_core_pkg::word_t      next_pc
);

  rv_core_pkg::word_t result;
  rv_core_pkg::word_t target;
  logic               rd_wen;

  // single adder covers addi, lui, auipc and the link value
  assign result = dec.op1 + dec.op2;

  // jalr drops bit 0 of the target
  always_comb begin
    target = dec.op1_jump + dec.op2_jump;
    if (dec.kind == rv_core_pkg::KIND_JALR) begin
      target[0] = 1'b0;
    end
  end

  // no write for x0, invalid or ebreak
  assign rd_wen = dec.rd_wen && (dec.rd_addr != '0) &&
                  (dec.kind != rv_core_pkg::KIND_INVALID) &&
                  (dec.kind != rv_core_pkg::KIND_EBREAK);

  // commit valid until accepted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exu_valid <= 1'b0;
    end else if (dec.dec_valid) begin
      exu_valid <= 1'b1;
    end else if (commit_fire) begin
      exu_valid <= 1'b0;
    end
  end

  // commit record, held stable under back-pressure
  always_ff @(posedge clk) begin
    if (dec.dec_valid) begin
      commit_pc     <= dec.pc;
      commit_inst   <= dec_inst;
      commit_kind   <= dec.kind;
      commit_rd_wen <= rd_wen;
      commit_rd     <= dec.rd_addr;
      commit_data   <= result;
      next_pc       <= dec.jump ? target : dec.pc + `RV_XLEN'(`RV_PC_STEP);
    end
  end

endmodule

// ==== verilog/rv_core_ctrl.sv ====
`include "rv_core_defs.svh"

module rv_core_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    inst_valid,
  input  logic                    commit_ready,
  input  logic                    exu_valid,
  input  rv_core_pkg::word_t      next_pc,
  input  rv_core_pkg::inst_kind_e commit_kind,
  output logic                    inst_ready,
  output logic                    dec_load,
  output rv_core_pkg::word_t      pc,
  output logic                    commit_valid,
  output logic                    commit_fire,
  output logic                    halted
);

  // one instruction between acceptance and commit
  logic busy;
  logic busy_nxt;
  logic halted_nxt;

  // both handshakes evaluated here only
  assign dec_load     = inst_valid && inst_ready;
  assign commit_valid = exu_valid;
  assign commit_fire  = exu_valid && commit_ready;

  // next state of busy and halt
  always_comb begin
    busy_nxt   = busy;
    halted_nxt = halted;
    if (dec_load) begin
      busy_nxt = 1'b1;
    end else if (commit_fire) begin
      busy_nxt = 1'b0;
    end
    // sticky until reset
    if (commit_fire && (commit_kind == rv_core_pkg::KIND_EBREAK)) begin
      halted_nxt = 1'b1;
    end
  end

  // ready is registered, so it stays low during reset
  // and rises on the cycle after a commit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      halted     <= 1'b0;
      inst_ready <= 1'b0;
    end else begin
      busy       <= busy_nxt;
      halted     <= halted_nxt;
      inst_ready <= !busy_nxt && !halted_nxt;
    end
  end

  // architectural pc, moves only when a commit is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (commit_fire) begin
      pc <= next_pc;
    end
  end

endmodule

// ==== verilog/rv_core_top.sv ====
module rv_core_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    inst_valid,
  input  rv_core_pkg::inst_t      inst,
  input  logic                    commit_ready,
  output logic                    inst_ready,
  output logic                    commit_valid,
  output rv_core_pkg::word_t      commit_pc,
  output rv_core_pkg::inst_t      commit_inst,
  output rv_core_pkg::inst_kind_e commit_kind,
  output logic                    commit_rd_wen,
  output rv_core_pkg::reg_addr_t  commit_rd,
  output rv_core_pkg::word_t      commit_data,
  output rv_core_pkg::word_t      commit_next_pc,
  output logic                    halted
);

  // ctrl to decoder
  logic                   dec_load;
  rv_core_pkg::word_t     pc;
  // decoder and register file read port
  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::word_t     rs1_data;
  rv_core_pkg::inst_t     dec_inst;
  // exu to ctrl
  logic                   exu_valid;
  logic                   commit_fire;
  // register write only on an accepted commit
  wire                    rf_wen = commit_fire & commit_rd_wen;

  rv_decode_if dec_bus ();

  rv_core_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .commit_ready (commit_ready),
    .exu_valid    (exu_valid),
    .next_pc      (commit_next_pc),
    .commit_kind  (commit_kind),
    .inst_ready   (inst_ready),
    .dec_load     (dec_load),
    .pc           (pc),
    .commit_valid (commit_valid),
    .commit_fire  (commit_fire),
    .halted       (halted)
  );

  rv_idu i_idu (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec_load (dec_load),
    .pc       (pc),
    .inst     (inst),
    .rs1_data (rs1_data),
    .rs1_addr (rs1_addr),
    .dec      (dec_bus.producer),
    .dec_inst (dec_inst)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .wen      (rf_wen),
    .waddr    (commit_rd),
    .wdata    (commit_data),
    .rs1_data (rs1_data)
  );

  rv_exu i_exu (
    .clk           (clk),
    .rst_n         (rst_n),
    .dec           (dec_bus.consumer),
    .dec_inst      (dec_inst),
    .commit_fire   (commit_fire),
    .exu_valid     (exu_valid),
    .commit_pc     (commit_pc),
    .commit_inst   (commit_inst),
    .commit_kind   (commit_kind),
    .commit_rd_wen (commit_rd_wen),
    .commit_rd     (commit_rd),
    .commit_data   (commit_data),
    .next_pc       (commit_next_pc)
  );

endmodule

// ==== verif/rv_core_tb.sv ====
`include "rv_core_defs.svh"

module rv_core_tb;

  localparam int          RESET_CYCLES    = 16;
  localparam int          CYCLES_PER_INST = 40;
  localparam logic [31:0] SEED            = 32'hb8184a47;
  // instructions issued per test
  localparam int N_UPPER = 6;
  localparam int N_ADDI  = 10;
  localparam int N_BP    = 10;
  // reset probe 1, x0 pair 2, jumps 4, invalid 3, ebreak 1, halt window 1
  localparam int N_TOTAL     = 1 + N_UPPER + N_ADDI + 2 + 4 + N_BP + 5;
  localparam int CYCLE_LIMIT = RESET_CYCLES + CYCLES_PER_INST * N_TOTAL;

  // rv64i major opcodes
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL   = 7'b1101111;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam rv_core_pkg::word_t PC_STEP = 64'd4;

  logic                    clk;
  logic                    rst_n;
  logic                    inst_valid;
  rv_core_pkg::inst_t      inst;
  logic                    commit_ready;
  logic                    inst_ready;
  logic                    commit_valid;
  rv_core_pkg::word_t      commit_pc;
  rv_core_pkg::inst_t      commit_inst;
  rv_core_pkg::inst_kind_e commit_kind;
  logic                    commit_rd_wen;
  rv_core_pkg::reg_addr_t  commit_rd;
  rv_core_pkg::word_t      commit_data;
  rv_core_pkg::word_t      commit_next_pc;
  logic                    halted;

  // shadow architectural state
  rv_core_pkg::word_t sh_regs [`RV_NREGS];
  rv_core_pkg::word_t sh_pc;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycles       = 0;

  rv_core_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .commit_ready   (commit_ready),
    .inst_ready     (inst_ready),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_inst    (commit_inst),
    .commit_kind    (commit_kind),
    .commit_rd_wen  (commit_rd_wen),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .commit_next_pc (commit_next_pc),
    .halted         (halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog, sized from the issue count
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // instruction encoders
  function automatic rv_core_pkg::inst_t enc_i(logic [6:0] opc, logic [4:0] rd,
                                               logic [2:0] f3, logic [4:0] rs1,
                                               logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_core_pkg::inst_t enc_u(logic [6:0] opc, logic [4:0] rd,
                                               logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // J layout is imm[20|10:1|11|19:12]
  function automatic rv_core_pkg::inst_t enc_j(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // immediate values as the ISA defines them
  function automatic rv_core_pkg::word_t sext12(logic [11:0] imm);
    return {{(`RV_XLEN-12){imm[11]}}, imm};
  endfunction

  function automatic rv_core_pkg::word_t sext21(logic [20:0] imm);
    return {{(`RV_XLEN-21){imm[20]}}, imm};
  endfunction

  function automatic rv_core_pkg::word_t upper20(logic [19:0] imm);
    return {{(`RV_XLEN-32){imm[19]}}, imm, 12'b0};
  endfunction

  task automatic compare_word(string name, rv_core_pkg::word_t got, rv_core_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_inst(string name, rv_core_pkg::inst_t got, rv_core_pkg::inst_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_reg_addr(string name, rv_core_pkg::reg_addr_t got,
                                  rv_core_pkg::reg_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got x%0d expected x%0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_kind(string name, rv_core_pkg::inst_kind_e got,
                              rv_core_pkg::inst_kind_e exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // inputs change 2 units after the edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic send_inst(rv_core_pkg::inst_t w);
    inst_valid = 1'b1;
    inst       = w;
    // ready is registered, its level here holds until the next edge
    while (!inst_ready) begin
      step();
    end
    step();
    inst_valid = 1'b0;
  endtask

  task automatic check_record(rv_core_pkg::inst_t w, rv_core_pkg::inst_kind_e kind,
                              rv_core_pkg::word_t data, rv_core_pkg::word_t npc,
                              logic writes);
    compare_word("commit_pc", commit_pc, sh_pc);
    compare_inst("commit_inst", commit_inst, w);
    compare_kind("commit_kind", commit_kind, kind);
    compare_bit("commit_rd_wen", commit_rd_wen, writes && (w[11:7] != 5'd0));
    // rd and data only mean something for writing kinds
    if (writes) begin
      compare_reg_addr("commit_rd", commit_rd, w[11:7]);
      compare_word("commit_data", commit_data, data);
    end
    compare_word("commit_next_pc", commit_next_pc, npc);
    // halt follows the accepted commit, never before
    compare_bit("halted", halted, 1'b0);
  endtask

  task automatic expect_commit(rv_core_pkg::inst_t w, rv_core_pkg::inst_kind_e kind,
                               rv_core_pkg::word_t data, rv_core_pkg::word_t npc, bit gaps);
    int   lat;
    int   stall;
    logic writes;
    lat          = 0;
    stall        = 0;
    writes       = (kind != rv_core_pkg::KIND_INVALID) && (kind != rv_core_pkg::KIND_EBREAK);
    commit_ready = 1'b0;
    // one instruction in flight, input side stays closed
    while (!commit_valid) begin
      compare_bit("inst_ready", inst_ready, 1'b0);
      step();
      lat++;
    end
    if (lat != 1) begin
      errors++;
      $display("commit_valid rose %0d cycles after acceptance instead of 2, at %0t",
               lat + 1, $time);
    end
    check_record(w, kind, data, npc, writes);
    commit_ready = gaps ? ($urandom_range(0, 2) == 0) : 1'b1;
    // record must hold while the consumer stalls
    while (!commit_ready) begin
      step();
      stall++;
      compare_bit("commit_valid", commit_valid, 1'b1);
      compare_bit("inst_ready", inst_ready, 1'b0);
      check_record(w, kind, data, npc, writes);
      commit_ready = (stall >= 8) || ($urandom_range(0, 2) == 0);
    end
    // handshake edge
    step();
    commit_ready = 1'b0;
    compare_bit("commit_valid", commit_valid, 1'b0);
    if (kind == rv_core_pkg::KIND_EBREAK) begin
      compare_bit("halted", halted, 1'b1);
      compare_bit("inst_ready", inst_ready, 1'b0);
    end else begin
      compare_bit("inst_ready", inst_ready, 1'b1);
    end
  endtask

  // one instruction through the core, then the shadow model steps
  task automatic issue(rv_core_pkg::inst_t w, rv_core_pkg::inst_kind_e kind,
                       rv_core_pkg::word_t data, rv_core_pkg::word_t npc, bit gaps);
    send_inst(w);
    expect_commit(w, kind, data, npc, gaps);
    if ((kind != rv_core_pkg::KIND_INVALID) && (kind != rv_core_pkg::KIND_EBREAK) &&
        (w[11:7] != 5'd0)) begin
      sh_regs[w[11:7]] = data;
    end
    sh_pc = npc;
  endtask

  task automatic report_test(string name, int e0);
    tests_run++;
    if (errors == e0) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s FAILED with %0d errors", name, errors - e0);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    // ready is still low right at release
    compare_bit("inst_ready", inst_ready, 1'b0);
    compare_bit("commit_valid", commit_valid, 1'b0);
    compare_bit("halted", halted, 1'b0);
    step();
    compare_bit("inst_ready", inst_ready, 1'b1);
    compare_bit("commit_valid", commit_valid, 1'b0);
    compare_bit("halted", halted, 1'b0);
    // first commit sits at the reset pc
    issue(enc_u(OP_LUI, 5'd1, 20'h12345), rv_core_pkg::KIND_LUI, upper20(20'h12345),
          `RV_RESET_PC + PC_STEP, 1'b0);
    report_test("reset", e0);
  endtask

  task automatic test_upper();
    int          e0;
    logic [19:0] imm;
    logic [4:0]  rd;
    e0 = errors;
    for (int i = 0; i < N_UPPER; i++) begin
      imm = 20'($urandom);
      // sign bit varies so both extensions show up
      imm[19] = i[1];
      rd = 5'($urandom_range(1, 31));
      if (i % 2 == 0) begin
        issue(enc_u(OP_LUI, rd, imm), rv_core_pkg::KIND_LUI, upper20(imm),
              sh_pc + PC_STEP, 1'b0);
      end else begin
        issue(enc_u(OP_AUIPC, rd, imm), rv_core_pkg::KIND_AUIPC, sh_pc + upper20(imm),
              sh_pc + PC_STEP, 1'b0);
      end
    end
    report_test("lui_auipc", e0);
  endtask

  // dependent addi chain, each rs1 is the previous rd
  task automatic test_addi_chain(string name, int count, bit gaps);
    int          e0;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    e0  = errors;
    rs1 = 5'd0;
    for (int i = 0; i < count; i++) begin
      imm = 12'($urandom);
      rd  = 5'($urandom_range(1, 31));
      issue(enc_i(OP_IMM, rd, 3'b000, rs1, imm), rv_core_pkg::KIND_ADDI,
            sh_regs[rs1] + sext12(imm), sh_pc + PC_STEP, gaps);
      rs1 = rd;
    end
    if (!gaps) begin
      // write to x0 is dropped
      imm = 12'($urandom);
      issue(enc_i(OP_IMM, 5'd0, 3'b000, rs1, imm), rv_core_pkg::KIND_ADDI,
            sh_regs[rs1] + sext12(imm), sh_pc + PC_STEP, 1'b0);
      // x0 still reads zero afterwards
      issue(enc_i(OP_IMM, 5'd3, 3'b000, 5'd0, imm), rv_core_pkg::KIND_ADDI,
            sext12(imm), sh_pc + PC_STEP, 1'b0);
    end
    report_test(name, e0);
  endtask

  task automatic test_jumps();
    int                 e0;
    logic [20:0]        off;
    logic [11:0]        imm;
    rv_core_pkg::word_t target;
    e0     = errors;
    off    = 21'($urandom);
    off[0] = 1'b0;
    issue(enc_j(5'd1, off), rv_core_pkg::KIND_JAL, sh_pc + PC_STEP, sh_pc + sext21(off), 1'b0);
    // commit_pc here must be the jal target, odd base for jalr
    imm = 12'($urandom) | 12'h001;
    issue(enc_i(OP_IMM, 5'd6, 3'b000, 5'd0, imm), rv_core_pkg::KIND_ADDI, sext12(imm),
          sh_pc + PC_STEP, 1'b0);
    // odd base plus even offset, bit 0 of the sum gets cleared
    imm    = 12'($urandom) & 12'hffe;
    target = (sh_regs[6] + sext12(imm)) & ~64'd1;
    issue(enc_i(OP_JALR, 5'd5, 3'b000, 5'd6, imm), rv_core_pkg::KIND_JALR, sh_pc + PC_STEP,
          target, 1'b0);
    // reads the link value at the redirected pc
    issue(enc_i(OP_IMM, 5'd7, 3'b000, 5'd5, 12'h010), rv_core_pkg::KIND_ADDI,
          sh_regs[5] + 64'h10, sh_pc + PC_STEP, 1'b0);
    report_test("jal_jalr", e0);
  endtask

  task automatic test_invalid_halt();
    int e0;
    e0 = errors;
    issue(32'h0000_0000, rv_core_pkg::KIND_INVALID, '0, sh_pc + PC_STEP, 1'b0);
    issue(32'hffff_ffff, rv_core_pkg::KIND_INVALID, '0, sh_pc + PC_STEP, 1'b0);
    // slti lies outside the subset
    issue(enc_i(OP_IMM, 5'd4, 3'b010, 5'd1, 12'h7ff), rv_core_pkg::KIND_INVALID, '0,
          sh_pc + PC_STEP, 1'b0);
    issue(32'h0010_0073, rv_core_pkg::KIND_EBREAK, '0, sh_pc + PC_STEP, 1'b0);
    // offer work, core must refuse it
    inst_valid = 1'b1;
    inst       = enc_i(OP_IMM, 5'd1, 3'b000, 5'd0, 12'h001);
    repeat (20) begin
      step();
      compare_bit("inst_ready", inst_ready, 1'b0);
      compare_bit("halted", halted, 1'b1);
      compare_bit("commit_valid", commit_valid, 1'b0);
    end
    inst_valid = 1'b0;
    report_test("invalid_halt", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst         = '0;
    commit_ready = 1'b0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      sh_regs[i] = '0;
    end
    sh_pc = `RV_RESET_PC;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset();
    test_upper();
    test_addi_chain("addi_chain", N_ADDI, 1'b0);
    test_jumps();
    test_addi_chain("backpressure", N_BP, 1'b1);
    test_invalid_halt();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
verilog/rv_core_pkg.sv
verilog/rv_decode_if.sv
verilog/rv_regfile.sv
verilog/rv_idu.sv
verilog/rv_exu.sv
verilog/rv_core_ctrl.sv
verilog/rv_core_top.sv
verif/rv_core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= rv_core_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST) include/rv_core_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Regression passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
